//--- project.f
+incdir+.
eth_pkg.sv
xgmii_tx_framer.sv
xgmii_elastic_buffer.sv
xgmii_rx_parser.sv
xge_loopback.sv
xge_asserts.sv
tb_xge_loopback.sv

//--- Makefile
SIM = obj_dir/Vtb_xge_loopback

.PHONY: compile run clean

compile: $(SIM)

$(SIM): project.f eth_cfg.svh eth_pkg.sv xgmii_tx_framer.sv xgmii_elastic_buffer.sv \
        xgmii_rx_parser.sv xge_loopback.sv xge_asserts.sv tb_xge_loopback.sv
	verilator --binary --timing --assert -f project.f --top-module tb_xge_loopback \
		-o Vtb_xge_loopback

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_xge_loopback.sv
`timescale 1ns/10ps
`include "eth_cfg.svh"

module tb_xge_loopback import eth_pkg::*; ();

    localparam int N_FRAMES = 150;

    logic        clk156_25;
    logic        rst;
    logic        tx_start;
    logic        tx_underrun;
    logic        tx_ack;
    logic        rx_good_frame;
    logic        rx_bad_frame;
    logic        buf_overflow;
    xgmii_data_t tx_data;
    xgmii_data_t rx_data;
    byte_mask_t  tx_data_valid;
    byte_mask_t  rx_data_valid;

    // Reference model queues
    logic [7:0] exp_bytes [$];      // Clean frame bytes back to back
    int         exp_len [$];        // Bytes per frame or 0 for underrun frames
    logic       exp_bad [$];
    logic [7:0] got_bytes [$];      // Frame now arriving
    int         errors;
    int         frames_sent;
    int         frames_rcvd;        // Every frame end seen on rx
    logic       timed_out;

    xge_loopback dut0 (
        .clk156_25(clk156_25),
        .rst(rst),
        .tx_start(tx_start),
        .tx_data(tx_data),
        .tx_data_valid(tx_data_valid),
        .tx_underrun(tx_underrun),
        .tx_ack(tx_ack),
        .rx_data(rx_data),
        .rx_data_valid(rx_data_valid),
        .rx_good_frame(rx_good_frame),
        .rx_bad_frame(rx_bad_frame),
        .buf_overflow(buf_overflow)
    );

    initial begin
        clk156_25 = 1'b0;
        forever #10 clk156_25 = ~clk156_25;     // 20 ns period
    end

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED t=%0t %s got 'h%0h expected 'h%0h", $time, sig, got, exp);
        errors++;
    endtask

    // Nonzero run of ones from lane 0 upward
    function automatic logic is_contig(input byte_mask_t m);
        logic [8:0] plus1;
        plus1 = {1'b0, m} + 9'd1;
        return (m != 8'h00) && ((plus1[7:0] & m) == 8'h00);
    endfunction

    // ----------------------------------------
    // Receive monitor
    // ----------------------------------------
    task automatic close_frame();
        int         len;
        logic       bad;
        logic [7:0] b;
        if (exp_len.size() == 0) begin
            $display("Frame end at %0t with no frame outstanding", $time);
            errors++;
        end else begin
            len = exp_len.pop_front();
            bad = exp_bad.pop_front();
            if (rx_bad_frame !== bad) report_mismatch("rx_bad_frame", 64'(rx_bad_frame), 64'(bad));
            if (rx_good_frame !== !bad)
                report_mismatch("rx_good_frame", 64'(rx_good_frame), 64'(!bad));
            if (!bad) begin
                if (got_bytes.size() != len)
                    report_mismatch("rx byte count", 64'(got_bytes.size()), 64'(len));
                for (int i = 0; i < len; i++) begin
                    b = exp_bytes.pop_front();      // Keep model aligned
                    if (i < got_bytes.size() && got_bytes[i] !== b)
                        report_mismatch("rx_data byte", 64'(got_bytes[i]), 64'(b));
                end
            end
        end
        got_bytes.delete();
    endtask

    // Sampled half a cycle after the outputs change
    always @(negedge clk156_25) begin
        if (!rst) begin
            if (rx_data_valid != 8'h00) begin
                if (exp_len.size() == 0) begin
                    $display("rx_data_valid high at %0t with no frame outstanding", $time);
                    errors++;
                end
                if (rx_good_frame || rx_bad_frame) begin
                    if (!is_contig(rx_data_valid))
                        report_mismatch("rx_data_valid", 64'(rx_data_valid), 64'(8'hff));
                end else if (rx_data_valid != 8'hff) begin
                    report_mismatch("rx_data_valid", 64'(rx_data_valid), 64'(8'hff));
                end
                for (int i = 0; i < 8; i++) begin
                    if (rx_data_valid[i]) got_bytes.push_back(rx_data[8*i +: 8]);
                end
            end else if (rx_good_frame || rx_bad_frame) begin
                $display("Frame end at %0t without rx_data_valid", $time);
                errors++;
            end
            if (rx_good_frame || rx_bad_frame) begin
                frames_rcvd++;
                close_frame();
            end
        end
    end

    // ----------------------------------------
    // Transmit stimulus
    // ----------------------------------------
    task automatic send_frame();
        int          n_words;
        int          n_last;        // Bytes in last word
        int          bad_word;      // Underrun word, -1 for none
        int          dup_word;      // Stray tx_start inside the frame
        int          waited;
        int          gap;
        byte_mask_t  last_mask;
        xgmii_data_t words [`MAX_FRAME_WORDS];
        n_words   = 1 + int'($urandom % `MAX_FRAME_WORDS);
        n_last    = 1 + int'($urandom % 8);
        bad_word  = ($urandom % 5 == 0) ? int'($urandom % n_words) : -1;
        dup_word  = 1 + int'($urandom % `MAX_FRAME_WORDS);     // May fall past the end
        last_mask = byte_mask_t'((9'h001 << n_last) - 9'h001);
        for (int w = 0; w < n_words; w++) words[w] = {$urandom, $urandom};
        exp_bad.push_back(bad_word >= 0);
        if (bad_word >= 0) begin
            exp_len.push_back(0);
        end else begin
            exp_len.push_back(8 * (n_words - 1) + n_last);
            for (int w = 0; w < n_words; w++) begin
                for (int b = 0; b < 8; b++) begin
                    if (w < n_words - 1 || b < n_last) exp_bytes.push_back(words[w][8*b +: 8]);
                end
            end
        end
        frames_sent++;
        tx_start = 1'b1;
        @(posedge clk156_25);
        #1;
        tx_start = 1'b0;
        waited   = 1;
        while (!tx_ack && waited < 10) begin
            @(posedge clk156_25);
            #1;
            waited++;
        end
        if (!tx_ack) begin
            $display("Timeout at %0t waiting for tx_ack", $time);
            errors++;
            timed_out = 1'b1;
            return;
        end
        if (waited != 1) report_mismatch("tx_ack delay", 64'(waited), 64'(1));
        // First word goes out in the ack cycle
        for (int w = 0; w < n_words; w++) begin
            tx_data       = words[w];
            tx_data_valid = (w == n_words - 1) ? last_mask : 8'hff;
            tx_underrun   = (w == bad_word);
            tx_start      = (w == dup_word);    // Framer must ignore it
            @(posedge clk156_25);
            #1;
            if (tx_ack !== 1'b0) report_mismatch("tx_ack", 64'(tx_ack), 64'(1'b0));
            if (w == bad_word) break;
        end
        tx_start      = 1'b0;
        tx_underrun   = 1'b0;
        tx_data       = '0;
        tx_data_valid = 8'h00;      // Empty mask closes a full last word
        gap = 2 + int'($urandom % 6);
        repeat (gap) begin
            @(posedge clk156_25);
            #1;
            if (tx_ack !== 1'b0) report_mismatch("tx_ack", 64'(tx_ack), 64'(1'b0));
        end
    endtask

    initial begin
        int waited;
        void'($urandom(80061));
        errors        = 0;
        frames_sent   = 0;
        frames_rcvd   = 0;
        timed_out     = 1'b0;
        rst           = 1'b1;
        tx_start      = 1'b0;
        tx_data       = '0;
        tx_data_valid = 8'h00;
        tx_underrun   = 1'b0;
        repeat (5) @(posedge clk156_25);
        #1;
        rst = 1'b0;
        if (tx_ack !== 1'b0) report_mismatch("tx_ack", 64'(tx_ack), 64'(1'b0));
        if (rx_data_valid !== 8'h00)
            report_mismatch("rx_data_valid", 64'(rx_data_valid), 64'(8'h00));
        if (rx_good_frame !== 1'b0) report_mismatch("rx_good_frame", 64'(rx_good_frame), 64'(0));
        if (rx_bad_frame !== 1'b0) report_mismatch("rx_bad_frame", 64'(rx_bad_frame), 64'(0));
        for (int f = 0; f < N_FRAMES && !timed_out; f++) send_frame();
        // Let the last frames drain through the buffer
        waited = 0;
        while (!timed_out && exp_len.size() != 0 && waited < 200) begin
            @(posedge clk156_25);
            #1;
            waited++;
        end
        if (exp_len.size() != 0) begin
            $display("Timeout with %0d frames never received", exp_len.size());
            errors++;
        end
        if (frames_rcvd != frames_sent)
            report_mismatch("frame count", 64'(frames_rcvd), 64'(frames_sent));
        if (buf_overflow !== 1'b0) report_mismatch("buf_overflow", 64'(buf_overflow), 64'(0));
        $display("Errors %0d, frames sent %0d, received %0d", errors, frames_sent, frames_rcvd);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- xge_asserts.sv
`timescale 1ns/10ps

module xge_asserts import eth_pkg::*; (
    input logic       clk156_25,
    input logic       rst,
    input logic       ack,          // Framer tx_ack
    input logic       good,
    input logic       bad,
    input byte_mask_t valid
);

    // ----------------------------------------
    // Receive side frame end
    // ----------------------------------------
    good_bad_exclusive: assert property (@(posedge clk156_25) disable iff (rst)
        !(good && bad))
        else $error("rx_good_frame and rx_bad_frame high together");

    end_has_data: assert property (@(posedge clk156_25) disable iff (rst)
        (good || bad) |-> (valid != 8'h00))     // Last word always carries bytes
        else $error("frame end without rx_data_valid");

    // Ack lasts exactly one cycle
    ack_single: assert property (@(posedge clk156_25) disable iff (rst)
        !(ack && $past(ack)))
        else $error("tx_ack high on two cycles in a row");

endmodule

bind xgmii_tx_framer xge_asserts tx_checks (
    .clk156_25(clk156_25),
    .rst(rst),
    .ack(tx_ack),
    .good(1'b0),
    .bad(1'b0),
    .valid(8'h00)
);

bind xgmii_rx_parser xge_asserts rx_checks (
    .clk156_25(clk156_25),
    .rst(rst),
    .ack(1'b0),
    .good(rx_good_frame),
    .bad(rx_bad_frame),
    .valid(rx_data_valid)
);

//--- xge_loopback.sv
`timescale 1ns/10ps

module xge_loopback import eth_pkg::*; (
    input  logic        clk156_25,
    input  logic        rst,
    // MAC tx
    input  logic        tx_start,
    input  xgmii_data_t tx_data,
    input  byte_mask_t  tx_data_valid,
    input  logic        tx_underrun,
    output logic        tx_ack,
    // MAC rx
    output xgmii_data_t rx_data,
    output byte_mask_t  rx_data_valid,
    output logic        rx_good_frame,
    output logic        rx_bad_frame,
    output logic        buf_overflow
);

    // ----------------------------------------
    // XGMII loopback path
    // ----------------------------------------
    xgmii_data_t xgmii_txd;
    xgmii_ctrl_t xgmii_txc;
    xgmii_data_t xgmii_rxd;
    xgmii_ctrl_t xgmii_rxc;

    xgmii_tx_framer framer0 (
        .clk156_25(clk156_25),              // I
        .rst(rst),                          // I
        .tx_start(tx_start),                // I
        .tx_data(tx_data),                  // I [63:0]
        .tx_data_valid(tx_data_valid),      // I [7:0]
        .tx_underrun(tx_underrun),          // I
        .tx_ack(tx_ack),                    // O
        .xgmii_txd(xgmii_txd),              // O [63:0]
        .xgmii_txc(xgmii_txc)               // O [7:0]
    );

    // Stands in for the serdes link
    xgmii_elastic_buffer buffer0 (
        .clk156_25(clk156_25),              // I
        .rst(rst),                          // I
        .in_d(xgmii_txd),                   // I [63:0]
        .in_c(xgmii_txc),                   // I [7:0]
        .out_d(xgmii_rxd),                  // O [63:0]
        .out_c(xgmii_rxc),                  // O [7:0]
        .buf_overflow(buf_overflow)         // O
    );

    xgmii_rx_parser parser0 (
        .clk156_25(clk156_25),              // I
        .rst(rst),                          // I
        .xgmii_rxd(xgmii_rxd),              // I [63:0]
        .xgmii_rxc(xgmii_rxc),              // I [7:0]
        .rx_data(rx_data),                  // O [63:0]
        .rx_data_valid(rx_data_valid),      // O [7:0]
        .rx_good_frame(rx_good_frame),      // O
        .rx_bad_frame(rx_bad_frame)         // O
    );

endmodule

//--- xgmii_rx_parser.sv
`timescale 1ns/10ps

module xgmii_rx_parser import eth_pkg::*; (
    input  logic        clk156_25,
    input  logic        rst,
    input  xgmii_data_t xgmii_rxd,
    input  xgmii_ctrl_t xgmii_rxc,
    output xgmii_data_t rx_data,
    output byte_mask_t  rx_data_valid,
    output logic        rx_good_frame,
    output logic        rx_bad_frame
);

    rx_state_t   state;
    xgmii_data_t hold_d;          // Column held back one cycle
    byte_mask_t  hold_mask;       // Zero when nothing is held
    logic        hold_last;       // Held column already carried the terminate
    logic        err_flag;        // Error code seen in this frame
    xgmii_char_t lane_c [8];
    logic [7:0]  term_hit;
    logic        term_any;
    logic [2:0]  term_lane;       // Lowest lane with FD
    logic        err_hit;
    logic        start_hit;
    logic        frame_end;

    // ----------------------------------------
    // Column decode
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            lane_c[i] = xgmii_rxd[8*i +: 8];
        end
    end

    always_comb begin
        term_hit  = '0;
        term_lane = 3'd0;
        err_hit   = 1'b0;
        for (int i = 7; i >= 0; i--) begin
            if (xgmii_rxc[i] && lane_c[i] == XGMII_TERM) begin
                term_hit[i] = 1'b1;
                term_lane   = 3'(i);        // Lowest lane wins
            end
            if (xgmii_rxc[i] && lane_c[i] == XGMII_ERROR) begin
                err_hit = 1'b1;
            end
        end
    end

    assign term_any  = |term_hit;
    assign start_hit = xgmii_rxc[0] && (lane_c[0] == XGMII_START);

    // ----------------------------------------
    // MAC receive side
    // ----------------------------------------
    assign rx_data       = hold_d;
    assign rx_data_valid = hold_mask;
    // Last word either carried FD itself or is followed by FD in lane 0
    assign frame_end     = (hold_mask != '0) && (hold_last || term_hit[0]);
    assign rx_good_frame = frame_end && !(err_flag || (term_hit[0] && err_hit));
    assign rx_bad_frame  = frame_end && (err_flag || (term_hit[0] && err_hit));

    always_ff @(posedge clk156_25) begin
        if (state == RX_DATA && !term_hit[0]) begin
            hold_d <= xgmii_rxd;
        end
    end

    always_ff @(posedge clk156_25) begin
        if (rst) begin
            state     <= RX_IDLE;
            hold_mask <= '0;
            hold_last <= 1'b0;
            err_flag  <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    hold_mask <= '0;                // Last word goes out once
                    hold_last <= 1'b0;
                    if (start_hit) begin
                        err_flag <= 1'b0;           // Start column dropped
                        state    <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (term_any && term_lane == 3'd0) begin
                        hold_mask <= '0;            // Held word closes this cycle
                        hold_last <= 1'b0;
                        state     <= RX_IDLE;
                    end else if (term_any) begin
                        hold_mask <= byte_mask_t'((8'h01 << term_lane) - 8'h01);
                        hold_last <= 1'b1;
                        err_flag  <= err_flag | err_hit;
                        state     <= RX_IDLE;
                    end else begin
                        hold_mask <= 8'hff;         // Data or error column
                        hold_last <= 1'b0;
                        err_flag  <= err_flag | err_hit;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- xgmii_elastic_buffer.sv
`timescale 1ns/10ps
`include "eth_cfg.svh"

module xgmii_elastic_buffer import eth_pkg::*; (
    input  logic        clk156_25,
    input  logic        rst,
    input  xgmii_data_t in_d,
    input  xgmii_ctrl_t in_c,
    output xgmii_data_t out_d,
    output xgmii_ctrl_t out_c,
    output logic        buf_overflow    // Sticky until reset
);

    localparam xgmii_data_t            IDLE_COL  = {8{XGMII_IDLE}};
    localparam logic [`BUF_ADDR_W:0]   FULL_LVL  = `BUF_DEPTH;
    localparam logic [`BUF_ADDR_W:0]   START_LVL = `BUF_START_LEVEL;

    xgmii_data_t            mem_d [`BUF_DEPTH];
    xgmii_ctrl_t            mem_c [`BUF_DEPTH];
    logic                   mem_t [`BUF_DEPTH];     // Entry holds a terminate
    logic [`BUF_ADDR_W-1:0] wr_ptr;
    logic [`BUF_ADDR_W-1:0] rd_ptr;
    logic [`BUF_ADDR_W:0]   count;                  // Occupancy
    logic [`BUF_ADDR_W:0]   term_cnt;               // Terminates stored
    logic                   draining;               // Frame released
    logic                   in_idle;
    logic                   in_term;
    logic                   full;
    logic                   wr_en;
    logic                   rd_en;
    logic                   wr_term;
    logic                   rd_term;

    always_comb begin
        in_term = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (in_c[i] && in_d[8*i +: 8] == XGMII_TERM) begin
                in_term = 1'b1;
            end
        end
    end

    assign in_idle = (in_c == 8'hff) && (in_d == IDLE_COL);  // Idles are not stored
    assign full    = (count == FULL_LVL);
    assign wr_en   = !in_idle && !full;
    assign rd_en   = draining && (count != '0);
    assign wr_term = wr_en && in_term;
    assign rd_term = rd_en && mem_t[rd_ptr];

    // Storage array
    always_ff @(posedge clk156_25) begin
        if (wr_en) begin
            mem_d[wr_ptr] <= in_d;
            mem_c[wr_ptr] <= in_c;
            mem_t[wr_ptr] <= in_term;
        end
    end

    // ----------------------------------------
    // Pointers, release and output
    // ----------------------------------------
    always_ff @(posedge clk156_25) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            term_cnt     <= '0;
            draining     <= 1'b0;
            buf_overflow <= 1'b0;
            out_d        <= IDLE_COL;
            out_c        <= 8'hff;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            count    <= count + {{`BUF_ADDR_W{1'b0}}, wr_en} - {{`BUF_ADDR_W{1'b0}}, rd_en};
            term_cnt <= term_cnt + {{`BUF_ADDR_W{1'b0}}, wr_term}
                                 - {{`BUF_ADDR_W{1'b0}}, rd_term};
            if (!in_idle && full) buf_overflow <= 1'b1;   // Column dropped
            if (rd_en) begin
                out_d <= mem_d[rd_ptr];
                out_c <= mem_c[rd_ptr];
            end else begin
                out_d <= IDLE_COL;                        // Idle refill
                out_c <= 8'hff;
            end
            // Stop after the terminate column, rearm on level or stored terminate
            if (rd_term) draining <= 1'b0;
            else if (!draining && (count >= START_LVL || term_cnt != '0)) draining <= 1'b1;
        end
    end

endmodule

//--- xgmii_tx_framer.sv
`timescale 1ns/10ps

module xgmii_tx_framer import eth_pkg::*; (
    input  logic        clk156_25,
    input  logic        rst,
    input  logic        tx_start,       // One-cycle request for a new frame
    input  xgmii_data_t tx_data,
    input  byte_mask_t  tx_data_valid,
    input  logic        tx_underrun,
    output logic        tx_ack,         // First word wanted this cycle
    output xgmii_data_t xgmii_txd,
    output xgmii_ctrl_t xgmii_txc
);

    // ----------------------------------------
    // Fixed columns
    // ----------------------------------------
    localparam xgmii_data_t IDLE_COL  = {8{XGMII_IDLE}};
    localparam xgmii_data_t START_COL = {PREAMBLE_SFD, {6{PREAMBLE_BYTE}}, XGMII_START};
    localparam xgmii_data_t TERM_COL  = {{7{XGMII_IDLE}}, XGMII_TERM};   // FD in lane 0
    localparam xgmii_data_t ERROR_COL = {8{XGMII_ERROR}};

    tx_state_t   state;
    logic [3:0]  n_bytes;       // Valid bytes in the word, 0 to 8
    xgmii_data_t word_d;        // Word with terminate and idle fill
    xgmii_ctrl_t word_c;

    // Ack is just the start-column cycle
    assign tx_ack = (state == TX_START);

    // Mask is contiguous, so the count is the terminate lane
    always_comb begin
        n_bytes = 4'd0;
        for (int i = 0; i < 8; i++) begin
            n_bytes = n_bytes + {3'd0, tx_data_valid[i]};
        end
    end

    // Data lanes below n_bytes, FD at n_bytes, idle above
    // Full mask gives a plain data column, empty mask a bare terminate
    always_comb begin
        word_d = tx_data;
        word_c = '0;
        for (int i = 0; i < 8; i++) begin
            if (i == int'(n_bytes)) begin
                word_d[8*i +: 8] = XGMII_TERM;
                word_c[i]        = 1'b1;
            end else if (i > int'(n_bytes)) begin
                word_d[8*i +: 8] = XGMII_IDLE;      // Fill after terminate
                word_c[i]        = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Column sequencer
    // ----------------------------------------
    always_ff @(posedge clk156_25) begin
        if (rst) begin
            state     <= TX_IDLE;
            xgmii_txd <= IDLE_COL;
            xgmii_txc <= 8'hff;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_start) begin
                        xgmii_txd <= START_COL;
                        xgmii_txc <= 8'h01;         // Only lane 0 is control
                        state     <= TX_START;
                    end else begin
                        xgmii_txd <= IDLE_COL;
                        xgmii_txc <= 8'hff;
                    end
                end
                TX_START, TX_DATA: begin
                    if (tx_underrun) begin
                        // Kill the frame, terminate follows
                        xgmii_txd <= ERROR_COL;
                        xgmii_txc <= 8'hff;
                        state     <= TX_TERM;
                    end else begin
                        xgmii_txd <= word_d;
                        xgmii_txc <= word_c;
                        // Anything short of a full word closes the frame
                        state     <= (tx_data_valid == 8'hff) ? TX_DATA : TX_IDLE;
                    end
                end
                TX_TERM: begin
                    xgmii_txd <= TERM_COL;
                    xgmii_txc <= 8'hff;
                    state     <= TX_IDLE;
                end
                default: begin
                    xgmii_txd <= IDLE_COL;
                    xgmii_txc <= 8'hff;
                    state     <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

//--- eth_pkg.sv
package eth_pkg;

    // Column and lane vectors
    typedef logic [63:0] xgmii_data_t;   // One XGMII column, lane 0 in [7:0]
    typedef logic [7:0]  xgmii_ctrl_t;   // One control bit per lane
    typedef logic [7:0]  byte_mask_t;    // MAC byte enables, from lane 0 up
    typedef logic [7:0]  xgmii_char_t;   // Single lane character

    // ----------------------------------------
    // XGMII control codes
    // ----------------------------------------
    localparam xgmii_char_t XGMII_IDLE    = 8'h07;
    localparam xgmii_char_t XGMII_START   = 8'hfb;
    localparam xgmii_char_t XGMII_TERM    = 8'hfd;
    localparam xgmii_char_t XGMII_ERROR   = 8'hfe;
    localparam xgmii_char_t PREAMBLE_SFD  = 8'hd5;   // Last byte of start column
    localparam xgmii_char_t PREAMBLE_BYTE = 8'h55;

    // Transmit framer steps
    typedef enum logic [1:0] {
        TX_IDLE,     // Idle columns, waiting for tx_start
        TX_START,    // Start column out, tx_ack high
        TX_DATA,     // One data column per word
        TX_TERM      // Extra terminate column after an underrun
    } tx_state_t;

    // Receive parser
    typedef enum logic {
        RX_IDLE,
        RX_DATA
    } rx_state_t;

endpackage

//--- eth_cfg.svh
`ifndef ETH_CFG_SVH
`define ETH_CFG_SVH

// ----------------------------------------
// Elastic buffer sizing
// ----------------------------------------
`define BUF_DEPTH        16     // Column entries
`define BUF_ADDR_W       4      // log2 of BUF_DEPTH
`define BUF_START_LEVEL  4      // Fill level that releases a frame

// ----------------------------------------
// Stimulus limits
// ----------------------------------------
// Longest frame in 64-bit words
`define MAX_FRAME_WORDS  8

`endif
